/* debug_unit.f */
common/mips_pkg.sv
common/debug_pkg.sv
common/rx_if.sv
common/report_if.sv
src/rx_frontend.sv
src/program_loader.sv
run_control/run_control.sv
src/report_serializer.sv
src/debug_unit.sv
verification/debug_unit_assert.sv
verification/tb_debug_unit.sv

/* Bender.yml */
package:
  name: debug_unit

sources:
  - common/mips_pkg.sv
  - common/debug_pkg.sv
  - common/rx_if.sv
  - common/report_if.sv
  - src/rx_frontend.sv
  - src/program_loader.sv
  - run_control/run_control.sv
  - src/report_serializer.sv
  - src/debug_unit.sv
  - target: test
    files:
      - verification/debug_unit_assert.sv
      - verification/tb_debug_unit.sv

/* verification/tb_debug_unit.sv */
module tb_debug_unit;
    timeunit 1ns;
    timeprecision 100ps;

    import mips_pkg::*;
    import debug_pkg::*;

    localparam int N_LATCH_WORDS   = 13;
    localparam int N_REGISTERS     = 32;
    localparam int PROG_ADDR_WIDTH = 10;
    localparam int REPORT_BYTES    = BYTES_PER_WORD * (N_LATCH_WORDS + N_REGISTERS) + 1;
    localparam int WAIT_LIMIT      = 400;  // Cycles per wait.

    logic                       i_clock = 1'b0;
    logic                       i_reset;
    logic                       i_rx_done;
    byte_t                      i_data_rx;
    logic                       i_soft_reset_ack;
    logic                       i_halt;
    word_t                      i_latch_word;
    word_t                      i_reg_word;
    logic                       o_tx_start;
    byte_t                      o_data_tx;
    logic                       o_soft_reset;
    logic                       o_prog_write;
    logic [PROG_ADDR_WIDTH-1:0] o_prog_addr;
    word_t                      o_prog_data;
    logic                       o_run_enable;
    logic                       o_step_mode;
    report_index_t              o_latch_select;
    reg_index_t                 o_reg_index;

    word_t latch_table [32];  // Processor model contents.
    word_t reg_table [32];
    byte_t exp_q [$];         // Bytes still expected on tx.
    word_t prog_words [$];
    int    tx_count = 0;
    int    writes_seen = 0;
    int    run_cycles = 0;
    int    halt_after = 0;    // Zero means no halt.
    int    ack_wait = 2;
    int    ack_timer = 0;
    int    mismatches = 0;
    int    other_errors = 0;
    bit    stalled = 1'b0;
    bit    ack_lowered = 1'b0;

    debug_unit #(
        .N_LATCH_WORDS   (N_LATCH_WORDS),
        .N_REGISTERS     (N_REGISTERS),
        .PROG_ADDR_WIDTH (PROG_ADDR_WIDTH)
    ) u_dut (.*);

    always #4 i_clock = ~i_clock;

    ////////////////////////////////////////////////////////////
    // Compare tasks and reference model.
    ////////////////////////////////////////////////////////////

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [PROG_ADDR_WIDTH-1:0] got,
                              input logic [PROG_ADDR_WIDTH-1:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            mismatches++;
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // Nth byte of a report: latches, registers, MSB first, then the end mark.
    function automatic byte_t report_byte(input int n);
        int    item;
        word_t w;
        item = n / BYTES_PER_WORD;
        if (item < N_LATCH_WORDS) begin
            w = latch_table[item];
        end else if (item < N_LATCH_WORDS + N_REGISTERS) begin
            w = reg_table[item - N_LATCH_WORDS];
        end else begin
            return BYTE_END_MARK;
        end
        return w[8 * (3 - n % BYTES_PER_WORD) +: 8];
    endfunction

    function automatic byte_t ack_for(input int n);
        if (n == REPORT_BYTES - 1) begin
            return 8'h28;
        end
        case (n % BYTES_PER_WORD)
            0:       return 8'h08;
            1:       return 8'h10;
            2:       return 8'h18;
            default: return 8'h20;
        endcase
    endfunction

    function automatic byte_t wrong_ack(input byte_t good);
        byte_t pick;
        case ($urandom_range(0, 5))
            0:       pick = 8'h08;
            1:       pick = 8'h10;
            2:       pick = 8'h18;
            3:       pick = 8'h20;
            4:       pick = 8'h28;
            default: pick = 8'h5A;  // Not an opcode at all.
        endcase
        if (pick == good) begin
            pick = 8'h5A;
        end
        return pick;
    endfunction

    ////////////////////////////////////////////////////////////
    // Processor model and output monitors.
    ////////////////////////////////////////////////////////////

    always @(negedge i_clock) begin
        if (!i_reset) begin
            i_soft_reset_ack = 1'b1;
            i_halt           = 1'b0;
            ack_timer        = 0;
        end else begin
            i_latch_word = latch_table[o_latch_select];
            i_reg_word   = reg_table[o_reg_index];
            if (!o_soft_reset) begin
                i_halt = 1'b0;
                if (ack_timer >= ack_wait) begin
                    i_soft_reset_ack = 1'b0;  // Reset taken.
                    ack_lowered      = 1'b1;
                end else begin
                    ack_timer++;
                end
            end else begin
                ack_timer        = 0;
                i_soft_reset_ack = 1'b1;
            end
            if (o_run_enable) begin
                run_cycles++;
                if (halt_after != 0 && run_cycles == halt_after) begin
                    i_halt = 1'b1;
                end
            end
        end
    end

    always @(negedge i_clock) begin
        if (i_reset && o_tx_start) begin
            tx_count++;
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("ERROR: unexpected transmit of byte 0x%h", o_data_tx);
            end else begin
                check_byte("o_data_tx", o_data_tx, exp_q.pop_front());
            end
        end
        if (i_reset && o_prog_write) begin
            if (writes_seen >= prog_words.size()) begin
                other_errors++;
                $display("ERROR: program write beyond the loaded image");
            end else begin
                check_addr("o_prog_addr", o_prog_addr, PROG_ADDR_WIDTH'(writes_seen));
                check_word("o_prog_data", o_prog_data, prog_words[writes_seen]);
            end
            writes_seen++;
        end
    end

    ////////////////////////////////////////////////////////////
    // Host side.
    ////////////////////////////////////////////////////////////

    task automatic tick(input string what, inout int cycles);
        @(negedge i_clock);
        cycles++;
        if (cycles > WAIT_LIMIT) begin
            other_errors++;
            stalled = 1'b1;  // Later waits fall through.
            $display("ERROR: timeout waiting for %s", what);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge i_clock);
    endtask

    task automatic send_byte(input byte_t b);
        @(negedge i_clock);
        i_data_rx = b;
        i_rx_done = 1'b1;
        @(negedge i_clock);
        i_rx_done = 1'b0;
        @(negedge i_clock);  // Byte held through the strobe cycle.
    endtask

    task automatic send_word(input word_t w);
        int n;
        for (n = BYTES_PER_WORD - 1; n >= 0; n--) begin
            send_byte(w[8 * n +: 8]);
        end
    endtask

    task automatic wait_tx_count(input int target);
        int cycles;
        cycles = 0;
        while (tx_count < target && !stalled) tick("a transmitted byte", cycles);
    endtask

    task automatic do_soft_reset();
        int base;
        int cycles;
        ack_wait    = $urandom_range(2, 8);
        ack_lowered = 1'b0;
        exp_q.push_back(BYTE_PC_READY);
        base = tx_count;
        send_byte(8'h00);
        cycles = 0;
        while (o_soft_reset && !stalled) tick("soft reset low", cycles);
        cycles = 0;
        while (!o_soft_reset && !stalled) tick("soft reset release", cycles);
        if (!stalled && !ack_lowered) begin
            other_errors++;
            $display("ERROR: soft reset released before the acknowledge");
        end
        wait_tx_count(base + 1);
        idle_cycles(6);
        check_count("ready byte count", tx_count - base, 1);
    endtask

    task automatic load_program(input int k);
        int    n;
        word_t w;
        prog_words.delete();
        writes_seen = 0;
        send_byte(8'h01);
        for (n = 0; n < k; n++) begin
            w = $urandom;
            if (w == HALT_WORD) begin
                w[0] = 1'b0;
            end
            prog_words.push_back(w);
            send_word(w);
        end
        send_word(HALT_WORD);
        idle_cycles(4);
        check_count("program write count", writes_seen, k);
    endtask

    task automatic ack_report(input int base, input bit slow);
        int n;
        for (n = 0; n < REPORT_BYTES && !stalled; n++) begin
            wait_tx_count(base + n + 1);
            if (slow) begin
                idle_cycles($urandom_range(0, 6));
                if ($urandom_range(0, 1) == 1) begin
                    send_byte(wrong_ack(ack_for(n)));
                    idle_cycles(3);
                end
                if (tx_count != base + n + 1) begin
                    other_errors++;
                    $display("ERROR: byte %0d started before its acknowledge", n + 1);
                end
            end
            send_byte(ack_for(n));
        end
    endtask

    task automatic run_session(input byte_t cmd, input int halt_at, input int exp_cycles,
                               input bit slow);
        int base;
        int n;
        int cycles;
        halt_after = halt_at;
        run_cycles = 0;
        for (n = 0; n < REPORT_BYTES; n++) begin
            exp_q.push_back(report_byte(n));
        end
        base = tx_count;
        send_byte(cmd);
        cycles = 0;
        while ((run_cycles == 0 || o_run_enable) && !stalled) tick("end of run", cycles);
        check_count("o_run_enable cycles", run_cycles, exp_cycles);
        check_flag("o_step_mode", o_step_mode, cmd == 8'h07);
        ack_report(base, slow);
        idle_cycles(4);
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("ERROR: report ended with %0d bytes missing", exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic expect_ignored(input byte_t cmd);
        int base;
        base = tx_count;
        run_cycles = 0;
        send_byte(cmd);
        idle_cycles(20);
        if (run_cycles != 0 || tx_count != base) begin
            other_errors++;
            $display("ERROR: start command 0x%h accepted without a new reset", cmd);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence.
    ////////////////////////////////////////////////////////////

    initial begin
        int n;
        int total;
        int halt_at;
        void'($urandom(29046));
        i_reset          = 1'b0;
        i_rx_done        = 1'b0;
        i_data_rx        = '0;
        i_soft_reset_ack = 1'b1;
        i_halt           = 1'b0;
        i_latch_word     = '0;
        i_reg_word       = '0;
        for (n = 0; n < 32; n++) begin
            latch_table[n] = $urandom;
            reg_table[n]   = $urandom;
        end
        repeat (3) @(negedge i_clock);
        i_reset = 1'b1;
        idle_cycles(2);

        // Continuous run, then a start without reset.
        do_soft_reset();
        load_program($urandom_range(4, 12));
        halt_at = $urandom_range(3, 15);
        run_session(8'h03, halt_at, halt_at, 1'b0);
        expect_ignored(8'h03);

        // Two steps under back-pressure, the second one halts.
        do_soft_reset();
        load_program($urandom_range(4, 12));
        run_session(8'h07, 0, 1, 1'b1);
        run_session(8'h07, 1, 1, 1'b1);
        expect_ignored(8'h07);

        total = mismatches + other_errors + u_dut.u_assert.assert_errors;
        $display("errors: mismatches %0d, other %0d, assertions %0d",
                 mismatches, other_errors, u_dut.u_assert.assert_errors);
        if (total == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* verification/debug_unit_assert.sv */
module debug_unit_assert (
    input logic            i_clock,
    input logic            i_reset,
    input logic            o_tx_start,
    input logic            o_prog_write,
    input mips_pkg::word_t o_prog_data,
    input logic            o_run_enable,
    input logic            o_step_mode
);
    timeunit 1ns;
    timeprecision 100ps;

    import mips_pkg::*;

    int assert_errors = 0;  // Failed assertions.

    // One start pulse per byte.
    assert property (@(posedge i_clock) disable iff (!i_reset)
        o_tx_start |=> !o_tx_start)
    else begin
        assert_errors++;
        $error("tx start high two cycles running");
    end

    // The halt word ends a load and is never stored.
    assert property (@(posedge i_clock) disable iff (!i_reset)
        o_prog_write |-> (o_prog_data != HALT_WORD))
    else begin
        assert_errors++;
        $error("program write carries the halt word");
    end

    // A single step enables the pipeline for one cycle.
    assert property (@(posedge i_clock) disable iff (!i_reset)
        o_run_enable && o_step_mode |=> !o_run_enable)
    else begin
        assert_errors++;
        $error("step run enable held past one cycle");
    end

endmodule

bind debug_unit debug_unit_assert u_assert (
    .i_clock      (i_clock),
    .i_reset      (i_reset),
    .o_tx_start   (o_tx_start),
    .o_prog_write (o_prog_write),
    .o_prog_data  (o_prog_data),
    .o_run_enable (o_run_enable),
    .o_step_mode  (o_step_mode)
);

/* src/debug_unit.sv */
module debug_unit #(
    parameter int N_LATCH_WORDS   = 13,
    parameter int N_REGISTERS     = 32,
    parameter int PROG_ADDR_WIDTH = 10
) (
    input  logic                     i_clock,
    input  logic                     i_reset,
    input  logic                     i_rx_done,
    input  mips_pkg::byte_t          i_data_rx,
    input  logic                     i_soft_reset_ack,
    input  logic                     i_halt,
    input  mips_pkg::word_t          i_latch_word,
    input  mips_pkg::word_t          i_reg_word,
    output logic                     o_tx_start,
    output mips_pkg::byte_t          o_data_tx,
    output logic                     o_soft_reset,
    output logic                     o_prog_write,
    output logic [PROG_ADDR_WIDTH-1:0] o_prog_addr,
    output mips_pkg::word_t          o_prog_data,
    output logic                     o_run_enable,
    output logic                     o_step_mode,
    output debug_pkg::report_index_t o_latch_select,
    output mips_pkg::reg_index_t     o_reg_index
);

    rx_if     rx_bus ();
    report_if report_bus ();

    logic load_active;
    logic load_done;
    logic pc_ready;

    rx_frontend u_rx_frontend (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_rx_done (i_rx_done),
        .i_data_rx (i_data_rx),
        .rx        (rx_bus.source)
    );

    program_loader #(
        .PROG_ADDR_WIDTH (PROG_ADDR_WIDTH)
    ) u_program_loader (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_load_active (load_active),
        .rx            (rx_bus.loader),
        .o_prog_write  (o_prog_write),
        .o_prog_addr   (o_prog_addr),
        .o_prog_data   (o_prog_data),
        .o_load_done   (load_done)
    );

    run_control #(
        .N_LATCH_WORDS (N_LATCH_WORDS),
        .N_REGISTERS   (N_REGISTERS)
    ) u_run_control (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .rx               (rx_bus.control),
        .i_soft_reset_ack (i_soft_reset_ack),
        .i_halt           (i_halt),
        .i_load_done      (load_done),
        .o_load_active    (load_active),
        .o_soft_reset     (o_soft_reset),
        .o_run_enable     (o_run_enable),
        .o_step_mode      (o_step_mode),
        .o_pc_ready       (pc_ready),
        .rep              (report_bus.requester)
    );

    report_serializer u_report_serializer (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .rx             (rx_bus.control),
        .rep            (report_bus.sender),
        .i_pc_ready     (pc_ready),
        .i_latch_word   (i_latch_word),
        .i_reg_word     (i_reg_word),
        .o_latch_select (o_latch_select),
        .o_reg_index    (o_reg_index),
        .o_tx_start     (o_tx_start),
        .o_data_tx      (o_data_tx)
    );

endmodule

/* src/report_serializer.sv */
module report_serializer (
    input  logic                     i_clock,
    input  logic                     i_reset,
    rx_if.control                    rx,
    report_if.sender                 rep,
    input  logic                     i_pc_ready,
    input  mips_pkg::word_t          i_latch_word,
    input  mips_pkg::word_t          i_reg_word,
    output debug_pkg::report_index_t o_latch_select,
    output mips_pkg::reg_index_t     o_reg_index,
    output logic                     o_tx_start,
    output mips_pkg::byte_t          o_data_tx
);
    import mips_pkg::*;
    import debug_pkg::*;

    localparam int POS_W = $clog2(BYTES_PER_WORD);

    logic             busy;
    logic [POS_W-1:0] pos;       // Byte now on the line.
    logic [POS_W-1:0] byte_pos;  // Byte to load next.
    word_t            word;
    byte_t            word_byte;
    byte_t            tx_byte;
    host_cmd_e        expected_ack;
    logic             ack_ok;
    logic             last_byte;
    logic             tx_fire;

    assign o_latch_select = (rep.src == SRC_LATCH) ? rep.index : '0;
    assign o_reg_index    = (rep.src == SRC_REGISTER) ? reg_index_t'(rep.index) : '0;

    assign word      = (rep.src == SRC_LATCH) ? i_latch_word : i_reg_word;
    assign byte_pos  = rep.start ? POS_W'(BYTES_PER_WORD - 1) : pos - 1'b1;
    assign word_byte = word[{byte_pos, 3'b000} +: 8];

    always_comb begin
        if (rep.src == SRC_END_MARK) begin
            expected_ack = CMD_ACK_END;
        end else begin
            case (pos)
                2'd3:    expected_ack = CMD_ACK_B3;
                2'd2:    expected_ack = CMD_ACK_B2;
                2'd1:    expected_ack = CMD_ACK_B1;
                default: expected_ack = CMD_ACK_B0;
            endcase
        end
    end

    // Wrong opcodes are simply ignored.
    assign ack_ok    = busy && rx.cmd_valid && (rx.cmd == expected_ack);
    assign last_byte = (rep.src == SRC_END_MARK) || (pos == '0);
    assign tx_fire   = rep.start || (ack_ok && !last_byte) || (i_pc_ready && !busy);

    always_comb begin
        if (!busy && !rep.start) begin
            tx_byte = BYTE_PC_READY;
        end else if (rep.src == SRC_END_MARK) begin
            tx_byte = BYTE_END_MARK;
        end else begin
            tx_byte = word_byte;
        end
    end

    ////////////////////////////////////////////////////////////
    // Transmit sequencing.
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            busy       <= 1'b0;
            pos        <= '0;
            o_tx_start <= 1'b0;
            rep.done   <= 1'b0;
        end else begin
            o_tx_start <= tx_fire;
            rep.done   <= ack_ok && last_byte;
            if (rep.start) begin
                busy <= 1'b1;
                pos  <= byte_pos;  // MSB first.
            end else if (ack_ok) begin
                if (last_byte) begin
                    busy <= 1'b0;
                end else begin
                    pos <= byte_pos;
                end
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (tx_fire) begin
            o_data_tx <= tx_byte;  // Held until the next start.
        end
    end

endmodule

/* run_control/run_control.sv */
module run_control #(
    parameter int N_LATCH_WORDS = 13,
    parameter int N_REGISTERS   = 32
) (
    input  logic        i_clock,
    input  logic        i_reset,
    rx_if.control       rx,
    input  logic        i_soft_reset_ack,
    input  logic        i_halt,
    input  logic        i_load_done,
    output logic        o_load_active,
    output logic        o_soft_reset,
    output logic        o_run_enable,
    output logic        o_step_mode,
    output logic        o_pc_ready,
    report_if.requester rep
);
    import debug_pkg::*;

    ctrl_state_e state;
    ctrl_state_e next_state;
    logic        start_cmd;
    logic        req_busy;
    logic        report_last;

    assign start_cmd   = rx.cmd_valid && (rx.cmd == CMD_RUN_CONT || rx.cmd == CMD_RUN_STEP);
    assign report_last = rep.done && (rep.src == SRC_END_MARK);

    ////////////////////////////////////////////////////////////
    // Session FSM.
    ////////////////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (rx.cmd_valid && rx.cmd == CMD_RESET) begin
                    next_state = ST_SOFT_RESET;
                end
            end
            ST_SOFT_RESET: begin
                if (!i_soft_reset_ack) begin
                    next_state = ST_WAIT_PC_ACK;  // Processor has taken the reset.
                end
            end
            ST_WAIT_PC_ACK: begin
                if (rx.cmd_valid && rx.cmd == CMD_PC_ACK) begin
                    next_state = ST_LOAD;
                end
            end
            ST_LOAD: begin
                if (i_load_done) begin
                    next_state = ST_WAIT_START;
                end
            end
            ST_WAIT_START: begin
                if (start_cmd) begin
                    next_state = ST_RUN;
                end
            end
            ST_RUN: begin
                // A step lasts one cycle, a continuous run waits for halt.
                if (o_step_mode || i_halt) begin
                    next_state = ST_REPORT;
                end
            end
            ST_REPORT: begin
                if (report_last) begin
                    next_state = (!o_step_mode || i_halt) ? ST_IDLE : ST_WAIT_START;
                end
            end
            default: next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            state       <= ST_IDLE;
            o_step_mode <= 1'b0;
            o_pc_ready  <= 1'b0;
            req_busy    <= 1'b0;
            rep.start   <= 1'b0;
            rep.src     <= SRC_LATCH;
            rep.index   <= '0;
        end else begin
            state      <= next_state;
            o_pc_ready <= (state == ST_SOFT_RESET) && !i_soft_reset_ack;  // Entry pulse.
            if (state == ST_WAIT_START && start_cmd) begin
                o_step_mode <= (rx.cmd == CMD_RUN_STEP);
            end

            // Report walk: latches, registers, then the end mark.
            rep.start <= 1'b0;
            if (state != ST_REPORT) begin
                req_busy  <= 1'b0;
                rep.src   <= SRC_LATCH;
                rep.index <= '0;
            end else if (!req_busy) begin
                rep.start <= 1'b1;
                req_busy  <= 1'b1;
            end else if (rep.done) begin
                req_busy <= 1'b0;
                case (rep.src)
                    SRC_LATCH: begin
                        if (rep.index == report_index_t'(N_LATCH_WORDS - 1)) begin
                            rep.src   <= SRC_REGISTER;
                            rep.index <= '0;
                        end else begin
                            rep.index <= rep.index + 1'b1;
                        end
                    end
                    SRC_REGISTER: begin
                        if (rep.index == report_index_t'(N_REGISTERS - 1)) begin
                            rep.src   <= SRC_END_MARK;
                            rep.index <= '0;
                        end else begin
                            rep.index <= rep.index + 1'b1;
                        end
                    end
                    default: rep.src <= SRC_END_MARK;  // FSM leaves the report here.
                endcase
            end
        end
    end

    assign o_load_active = (state == ST_LOAD);
    assign o_soft_reset  = (state != ST_SOFT_RESET);  // Active low.
    assign o_run_enable  = (state == ST_RUN);

endmodule

/* src/program_loader.sv */
module program_loader #(
    parameter int PROG_ADDR_WIDTH = 10
) (
    input  logic                       i_clock,
    input  logic                       i_reset,
    input  logic                       i_load_active,
    rx_if.loader                       rx,
    output logic                       o_prog_write,
    output logic [PROG_ADDR_WIDTH-1:0] o_prog_addr,
    output mips_pkg::word_t            o_prog_data,
    output logic                       o_load_done
);
    import mips_pkg::*;

    localparam int CNT_W   = $clog2(BYTES_PER_WORD);
    localparam int SHIFT_W = $bits(word_t) - $bits(byte_t);

    logic [CNT_W-1:0]   byte_count;
    logic [SHIFT_W-1:0] shift_word;
    word_t              next_word;
    logic               word_ready;

    // Most significant byte arrives first.
    assign next_word  = {shift_word, rx.data};
    assign word_ready = i_load_active && rx.strobe &&
                        (byte_count == CNT_W'(BYTES_PER_WORD - 1));

    ////////////////////////////////////////////////////////////
    // Byte counter, address and strobes.
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            byte_count   <= '0;
            o_prog_addr  <= '0;
            o_prog_write <= 1'b0;
            o_load_done  <= 1'b0;
        end else begin
            o_prog_write <= word_ready && (next_word != HALT_WORD);
            o_load_done  <= word_ready && (next_word == HALT_WORD);
            if (!i_load_active) begin
                byte_count  <= '0;  // Fresh image each load.
                o_prog_addr <= '0;
            end else begin
                if (rx.strobe) begin
                    byte_count <= byte_count + 1'b1;  // Wraps after last byte.
                end
                if (o_prog_write) begin
                    o_prog_addr <= o_prog_addr + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (rx.strobe) begin
            shift_word <= next_word[SHIFT_W-1:0];
        end
        if (word_ready) begin
            o_prog_data <= next_word;  // Valid with the write strobe.
        end
    end

endmodule

/* src/rx_frontend.sv */
module rx_frontend (
    input  logic            i_clock,
    input  logic            i_reset,
    input  logic            i_rx_done,
    input  mips_pkg::byte_t i_data_rx,
    rx_if.source            rx
);
    import debug_pkg::*;

    logic rx_done_q;

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            rx_done_q <= 1'b0;
        end else begin
            rx_done_q <= i_rx_done;
        end
    end

    // Byte is taken on the falling edge of rx_done.
    assign rx.strobe = rx_done_q && !i_rx_done;
    assign rx.data   = i_data_rx;

    always_comb begin
        case (i_data_rx)
            8'h00:   rx.cmd = CMD_RESET;
            8'h01:   rx.cmd = CMD_PC_ACK;
            8'h03:   rx.cmd = CMD_RUN_CONT;
            8'h07:   rx.cmd = CMD_RUN_STEP;
            8'h08:   rx.cmd = CMD_ACK_B3;
            8'h10:   rx.cmd = CMD_ACK_B2;
            8'h18:   rx.cmd = CMD_ACK_B1;
            8'h20:   rx.cmd = CMD_ACK_B0;
            8'h28:   rx.cmd = CMD_ACK_END;
            default: rx.cmd = CMD_NONE;  // Program bytes land here.
        endcase
    end

    assign rx.cmd_valid = rx.strobe && (rx.cmd != CMD_NONE);

endmodule

/* common/report_if.sv */
interface report_if;
    import debug_pkg::*;

    logic          start;  // Pulse, one item requested.
    report_src_e   src;    // Held until done.
    report_index_t index;  // Held until done.
    logic          done;   // Pulse after the last acknowledge.

    modport requester (
        output start, src, index,
        input  done
    );

    modport sender (
        input  start, src, index,
        output done
    );

endinterface

/* common/rx_if.sv */
interface rx_if;
    import mips_pkg::*;
    import debug_pkg::*;

    logic      strobe;     // One cycle per received byte.
    byte_t     data;
    host_cmd_e cmd;
    logic      cmd_valid;  // Strobe with a known opcode.

    modport source  (output strobe, data, cmd, cmd_valid);
    modport loader  (input strobe, data);
    modport control (input cmd_valid, cmd);

endinterface

/* common/debug_pkg.sv */
package debug_pkg;

    ////////////////////////////////////////////////////////////
    // Host protocol opcodes.
    ////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        CMD_RESET,     // Byte 0x00.
        CMD_PC_ACK,    // Byte 0x01.
        CMD_RUN_CONT,  // Byte 0x03.
        CMD_RUN_STEP,  // Byte 0x07.
        CMD_ACK_B3,    // Byte 0x08.
        CMD_ACK_B2,    // Byte 0x10.
        CMD_ACK_B1,    // Byte 0x18.
        CMD_ACK_B0,    // Byte 0x20.
        CMD_ACK_END,   // Byte 0x28.
        CMD_NONE       // Anything else.
    } host_cmd_e;

    ////////////////////////////////////////////////////////////
    // Run controller and report sequencing.
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SOFT_RESET,
        ST_WAIT_PC_ACK,
        ST_LOAD,
        ST_WAIT_START,
        ST_RUN,
        ST_REPORT
    } ctrl_state_e;

    typedef enum logic [1:0] {
        SRC_LATCH,     // Pipeline-latch word.
        SRC_REGISTER,  // Register-file word.
        SRC_END_MARK   // Single closing byte.
    } report_src_e;

    typedef logic [4:0] report_index_t;

    localparam mips_pkg::byte_t BYTE_PC_READY = 8'h01;  // Sent once soft reset is done.
    localparam mips_pkg::byte_t BYTE_END_MARK = 8'h0B;  // Closes a report.

endpackage

/* common/mips_pkg.sv */
package mips_pkg;

    ////////////////////////////////////////////////////////////
    // Processor-side data widths.
    ////////////////////////////////////////////////////////////

    typedef logic [7:0]  byte_t;       // One UART byte.
    typedef logic [31:0] word_t;       // Instruction, register or latch word.
    typedef logic [4:0]  reg_index_t;  // Register-file index.

    // All-ones word ends a program image.
    localparam word_t HALT_WORD = 32'hFFFF_FFFF;

    localparam int BYTES_PER_WORD = 4;  // Word travels as four bytes.

endpackage
